//--- logic/gauss_pkg.sv
// ######################################
// Matrix dimensions, row and index types
// Step engine state encoding
// ######################################

package gauss_pkg;

  // Matrix shape, ROW_CNT is also the pivot column count
  localparam int ROW_CNT = 8;
  localparam int COL_CNT = 16;

  typedef logic [COL_CNT-1:0] row_t;                  // One matrix row
  typedef logic [$clog2(ROW_CNT)-1:0] row_addr_t;     // Row index
  typedef logic [$clog2(COL_CNT)-1:0] col_idx_t;      // Bit position in a row

  // Block index, one spare code so BLOCK_W of 1 still fits
  typedef logic [$clog2(ROW_CNT+1)-1:0] blk_idx_t;

  // Step engine FSM
  typedef enum logic [2:0] {
    S_IDLE,       // Waiting for step_start
    S_SEARCH,     // Scanning rows for a pivot
    S_SWAP_RD,    // Fetch row c
    S_SWAP_WR,    // Two writes exchange rows
    S_ELIM_RD,    // First elimination read
    S_ELIM_WR,    // Pipelined read and XOR write
    S_NEXT_COL    // Advance column or finish
  } step_state_t;

endpackage

//--- logic/row_mem_if.sv
// ######################################
// Engine side row memory port
// ######################################

`timescale 1ns/1ns

interface row_mem_if import gauss_pkg::*; ();

  logic      rd_en;
  row_addr_t rd_addr;
  row_t      rd_data;   // Valid the cycle after rd_en
  logic      wr_en;
  row_addr_t wr_addr;
  row_t      wr_data;

  // Step engine side
  modport engine (output rd_en, rd_addr, wr_en, wr_addr, wr_data,
                  input  rd_data);

  // Memory side
  modport mem (input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
               output rd_data);

endinterface

//--- logic/row_mem.sv
// ######################################
// Row memory with host and engine ports
// ######################################

`timescale 1ns/1ns

module row_mem import gauss_pkg::*; (
  input  logic      clk,
  input  logic      busy,           // Engine owns the memory when high
  input  logic      host_rd_en,
  input  row_addr_t host_rd_addr,
  output row_t      host_rd_data,
  input  logic      host_wr_en,
  input  row_addr_t host_wr_addr,
  input  row_t      host_wr_data,
  row_mem_if.mem    mem
);

  row_t rows [ROW_CNT];   // Matrix storage, host always loads it
  row_t rd_q;             // Shared read register

  logic      rd_en;
  row_addr_t rd_addr;
  logic      wr_en;
  row_addr_t wr_addr;
  row_t      wr_data;

  // Port select, host requests dropped while a run is active
  always_comb begin
    if (busy) begin
      rd_en   = mem.rd_en;
      rd_addr = mem.rd_addr;
      wr_en   = mem.wr_en;
      wr_addr = mem.wr_addr;
      wr_data = mem.wr_data;
    end else begin
      rd_en   = host_rd_en;
      rd_addr = host_rd_addr;
      wr_en   = host_wr_en;
      wr_addr = host_wr_addr;
      wr_data = host_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en)
      rows[wr_addr] <= wr_data;
    if (rd_en)
      rd_q <= rows[rd_addr];   // Old data on same-address write
  end

  // One-cycle read latency on both sides
  assign mem.rd_data  = rd_q;
  assign host_rd_data = rd_q;

endmodule

//--- logic/gauss_step.sv
// ######################################
// Step engine, pivots and eliminates the
// BLOCK_W columns of one column block
// ######################################

`timescale 1ns/1ns

module gauss_step import gauss_pkg::*; #(
  parameter int BLOCK_W = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         step_start,
  input  blk_idx_t     col_block,   // Stable for the whole step
  output logic         step_done,
  output logic         step_fail,
  row_mem_if.engine    mem
);

  localparam row_addr_t LAST_ROW = row_addr_t'(ROW_CNT - 1);

  step_state_t state_q;
  col_idx_t    col_q;       // Current pivot column c
  row_addr_t   scan_addr;   // Next row to read in search or elimination
  logic        scan_more;   // Rows left to issue
  logic        swap_ph;     // Second swap write
  logic        rd_vld;      // rd_data belongs to a read of last cycle
  row_addr_t   rd_tag;      // Row held in rd_data
  row_t        pivot_q;     // Pivot row, XORed into the others
  row_addr_t   piv_addr;    // Where the pivot was found

  col_idx_t    col_base;
  col_idx_t    col_end;
  row_addr_t   col_row;     // Row c, target of the pivot
  logic        piv_bit;
  logic        srch_hit;
  logic        srch_miss;

  logic        rd_en;
  row_addr_t   rd_addr;
  logic        wr_en;
  row_addr_t   wr_addr;
  row_t        wr_data;

  // First and last pivot column of this block
  assign col_base = col_idx_t'(col_block * BLOCK_W);
  assign col_end  = col_idx_t'(col_block * BLOCK_W + BLOCK_W - 1);
  assign col_row  = row_addr_t'(col_q);

  assign piv_bit   = mem.rd_data[col_q];
  assign srch_hit  = (state_q == S_SEARCH) && rd_vld && piv_bit;   // Lowest candidate wins
  assign srch_miss = (state_q == S_SEARCH) && rd_vld && !piv_bit &&
                     (rd_tag == LAST_ROW);                         // Column is empty

  // Memory requests
  always_comb begin
    rd_en   = 1'b0;
    rd_addr = scan_addr;
    wr_en   = 1'b0;
    wr_addr = rd_tag;
    wr_data = mem.rd_data ^ pivot_q;   // Elimination result
    case (state_q)
      S_SEARCH: begin
        rd_en = scan_more && !srch_hit;   // Stop issuing once found
      end
      S_SWAP_RD: begin
        rd_en   = 1'b1;
        rd_addr = col_row;
      end
      S_SWAP_WR: begin
        wr_en = 1'b1;
        if (!swap_ph) begin
          wr_addr = piv_addr;         // Old row c into the pivot slot
          wr_data = mem.rd_data;
        end else begin
          wr_addr = col_row;          // Pivot into row c
          wr_data = pivot_q;
        end
      end
      S_ELIM_RD: begin
        rd_en = scan_more;
      end
      S_ELIM_WR: begin
        rd_en = scan_more;            // Next row read overlaps this write
        wr_en = rd_vld && (rd_tag != col_row) && piv_bit;
      end
      default: begin
      end
    endcase
  end

  assign mem.rd_en   = rd_en;
  assign mem.rd_addr = rd_addr;
  assign mem.wr_en   = wr_en;
  assign mem.wr_addr = wr_addr;
  assign mem.wr_data = wr_data;

  // Control FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      col_q     <= '0;
      scan_addr <= '0;
      scan_more <= 1'b0;
      swap_ph   <= 1'b0;
      rd_vld    <= 1'b0;
      step_done <= 1'b0;
      step_fail <= 1'b0;
    end else begin
      rd_vld    <= rd_en;
      step_done <= 1'b0;
      step_fail <= 1'b0;
      // Scan pointer walks on each search or elimination read
      if (rd_en && (state_q != S_SWAP_RD)) begin
        scan_addr <= scan_addr + 1'b1;
        scan_more <= (scan_addr != LAST_ROW);
      end
      case (state_q)
        S_IDLE: begin
          if (step_start) begin
            col_q     <= col_base;
            scan_addr <= row_addr_t'(col_base);   // Search from row c up
            scan_more <= 1'b1;
            state_q   <= S_SEARCH;
          end
        end
        S_SEARCH: begin
          if (srch_hit) begin
            scan_addr <= '0;              // Elimination covers all rows
            scan_more <= 1'b1;
            state_q   <= (rd_tag == col_row) ? S_ELIM_RD : S_SWAP_RD;
          end else if (srch_miss) begin
            step_done <= 1'b1;            // Singular, abort the step
            step_fail <= 1'b1;
            state_q   <= S_IDLE;
          end
        end
        S_SWAP_RD: begin
          swap_ph <= 1'b0;
          state_q <= S_SWAP_WR;
        end
        S_SWAP_WR: begin
          if (!swap_ph)
            swap_ph <= 1'b1;
          else
            state_q <= S_ELIM_RD;
        end
        S_ELIM_RD: state_q <= S_ELIM_WR;
        S_ELIM_WR: begin
          if (rd_vld && (rd_tag == LAST_ROW))
            state_q <= S_NEXT_COL;        // Last row handled
        end
        S_NEXT_COL: begin
          if (col_q == col_end) begin
            step_done <= 1'b1;
            state_q   <= S_IDLE;
          end else begin
            col_q     <= col_q + 1'b1;
            scan_addr <= row_addr_t'(col_q + 1'b1);
            scan_more <= 1'b1;
            state_q   <= S_SEARCH;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Read tag and pivot capture
  always_ff @(posedge clk) begin
    rd_tag <= rd_addr;
    if (srch_hit) begin
      pivot_q  <= mem.rd_data;
      piv_addr <= rd_tag;
    end
  end

endmodule

//--- logic/gauss_phase.sv
// ######################################
// Phase controller, runs one step per
// column block, done and fail flags
// ######################################

`timescale 1ns/1ns

module gauss_phase import gauss_pkg::*; #(
  parameter int BLOCK_W = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  blk_idx_t start_block,
  input  logic     step_done,
  input  logic     step_fail,
  output logic     step_start,
  output blk_idx_t col_block,
  output logic     busy,
  output logic     done,
  output logic     fail
);

  localparam blk_idx_t LAST_BLK = blk_idx_t'(ROW_CNT / BLOCK_W - 1);

  logic running_q;   // A run is active
  logic skip_q;      // Start block past the end, nothing to do
  logic start_ok;
  logic last_blk;
  logic step_more;
  logic run_end;

  assign start_ok  = start && !running_q;   // Ignore start mid-run
  assign last_blk  = (col_block == LAST_BLK);
  assign step_more = running_q && step_done && !step_fail && !last_blk;
  assign run_end   = running_q &&
                     (skip_q || (step_done && (step_fail || last_blk)));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running_q  <= 1'b0;
      skip_q     <= 1'b0;
      col_block  <= '0;
      step_start <= 1'b0;
      done       <= 1'b0;
      fail       <= 1'b0;
    end else begin
      step_start <= 1'b0;
      done       <= 1'b0;
      if (start_ok) begin
        running_q  <= 1'b1;
        col_block  <= start_block;
        skip_q     <= (start_block > LAST_BLK);
        step_start <= (start_block <= LAST_BLK);   // First step a cycle after start
        fail       <= 1'b0;                        // Cleared only by a new run
      end else if (run_end) begin
        running_q <= 1'b0;
        skip_q    <= 1'b0;
        done      <= 1'b1;                         // busy drops with done
        fail      <= !skip_q && step_fail;
      end else if (step_more) begin
        col_block  <= blk_idx_t'(col_block + 1'b1);
        step_start <= 1'b1;                        // Next block
      end
    end
  end

  assign busy = running_q;

endmodule

//--- logic/gf2_systemizer.sv
// ######################################
// GF(2) systemizer top level
// ######################################

`timescale 1ns/1ns

module gf2_systemizer import gauss_pkg::*; #(
  parameter int BLOCK_W = 4   // 1, 2, 4 or 8
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  blk_idx_t  start_block,
  output logic      busy,
  output logic      done,
  output logic      fail,
  input  logic      host_rd_en,
  input  row_addr_t host_rd_addr,
  output row_t      host_rd_data,
  input  logic      host_wr_en,
  input  row_addr_t host_wr_addr,
  input  row_t      host_wr_data
);

  logic     step_start;
  logic     step_done;
  logic     step_fail;
  blk_idx_t col_block;

  row_mem_if mem_if ();   // Engine to memory

  gauss_phase #(.BLOCK_W(BLOCK_W)) gauss_phase_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .start_block (start_block),
    .step_done   (step_done),
    .step_fail   (step_fail),
    .step_start  (step_start),
    .col_block   (col_block),
    .busy        (busy),
    .done        (done),
    .fail        (fail)
  );

  gauss_step #(.BLOCK_W(BLOCK_W)) gauss_step_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .step_start (step_start),
    .col_block  (col_block),
    .step_done  (step_done),
    .step_fail  (step_fail),
    .mem        (mem_if.engine)
  );

  row_mem row_mem_i (
    .clk          (clk),
    .busy         (busy),
    .host_rd_en   (host_rd_en),
    .host_rd_addr (host_rd_addr),
    .host_rd_data (host_rd_data),
    .host_wr_en   (host_wr_en),
    .host_wr_addr (host_wr_addr),
    .host_wr_data (host_wr_data),
    .mem          (mem_if.mem)
  );

endmodule

//--- sim/gf2_systemizer_checker.sv
// ######################################
// Control protocol assertions for the
// phase controller
// ######################################

`timescale 1ns/1ns

module gf2_systemizer_checker (
  input logic clk,
  input logic rst_n,
  input logic step_start,
  input logic step_done,
  input logic busy,
  input logic done,
  input logic fail
);

  logic step_active;      // Between step_start and step_done
  int   assert_fails = 0; // Failed assertion count

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      step_active <= 1'b0;
    else if (step_start)
      step_active <= 1'b1;
    else if (step_done)
      step_active <= 1'b0;
  end

  // done lasts one cycle only
  done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      $error("done held for more than one cycle");
      assert_fails++;
    end

  // busy drops only with done, and done only ends a busy run
  busy_fall: assert property (@(posedge clk) disable iff (!rst_n) $fell(busy) |-> done)
    else begin
      $error("busy fell without done");
      assert_fails++;
    end
  done_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy && $past(busy))
    else begin
      $error("done without busy falling");
      assert_fails++;
    end

  no_overlap: assert property (@(posedge clk) disable iff (!rst_n) step_start |-> !step_active)
    else begin
      $error("step_start while a step runs");
      assert_fails++;
    end

  fail_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(fail) |-> done)
    else begin
      $error("fail rose without done");
      assert_fails++;
    end

endmodule

//--- sim/gf2_systemizer_tb.sv
// ######################################
// Testbench for the GF(2) systemizer,
// records from the tests data file
// ######################################

`timescale 1ns/1ns

module gf2_systemizer_tb import gauss_pkg::*; ();

  localparam int BLOCK_W      = 4;
  localparam int NUM_TESTS    = 5;
  localparam int REC_LEN      = 2 * ROW_CNT + 3;   // code, block, rows, fail, rows
  localparam int WATCHDOG_CYC = NUM_TESTS * (ROW_CNT * ROW_CNT * 4 + 100);

  logic      clk;
  logic      rst_n;
  logic      start;
  blk_idx_t  start_block;
  logic      busy;
  logic      done;
  logic      fail;
  logic      host_rd_en;
  row_addr_t host_rd_addr;
  row_t      host_rd_data;
  logic      host_wr_en;
  row_addr_t host_wr_addr;
  row_t      host_wr_data;

  row_t tests [NUM_TESTS * REC_LEN];   // Whole data file
  int   err_cnt;
  int   pass_cnt;
  int   fail_cnt;

  gf2_systemizer #(.BLOCK_W(BLOCK_W)) gf2_systemizer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .start_block  (start_block),
    .busy         (busy),
    .done         (done),
    .fail         (fail),
    .host_rd_en   (host_rd_en),
    .host_rd_addr (host_rd_addr),
    .host_rd_data (host_rd_data),
    .host_wr_en   (host_wr_en),
    .host_wr_addr (host_wr_addr),
    .host_wr_data (host_wr_data)
  );

  bind gauss_phase gf2_systemizer_checker checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .step_start (step_start),
    .step_done  (step_done),
    .busy       (busy),
    .done       (done),
    .fail       (fail)
  );

  always #2 clk = ~clk;   // 4 ns period

  task automatic check_row(input row_t got, input row_t exp, input string msg);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  // Host port access, called on a falling edge
  task automatic write_row(input row_addr_t addr, input row_t data);
    host_wr_en   = 1'b1;
    host_wr_addr = addr;
    host_wr_data = data;
    @(negedge clk);
    host_wr_en   = 1'b0;
  endtask

  task automatic read_row(input row_addr_t addr, output row_t data);
    host_rd_en   = 1'b1;
    host_rd_addr = addr;
    @(negedge clk);           // Registered read
    host_rd_en   = 1'b0;
    data         = host_rd_data;
  endtask

  // Start a run and wait for done, host writes kept busy meanwhile
  task automatic run_engine(input blk_idx_t blk);
    int cyc;
    start       = 1'b1;
    start_block = blk;
    @(negedge clk);
    start = 1'b0;
    check_flag(busy, 1'b1, "busy one cycle after start");
    check_flag(fail, 1'b0, "fail cleared by start");
    cyc = 1;
    while (!done) begin
      host_wr_en   = busy;              // Must be ignored by the memory
      host_wr_addr = row_addr_t'(cyc);
      host_wr_data = ~row_t'(cyc);
      @(negedge clk);
      cyc++;
    end
    host_wr_en = 1'b0;
    if (blk >= ROW_CNT / BLOCK_W)
      check_flag(cyc == 2, 1'b1, "done two cycles after a skipped start");
  endtask

  initial begin
    int   base;
    int   errs_before;
    row_t got;
    clk          = 1'b0;
    rst_n        = 1'b0;
    start        = 1'b0;
    start_block  = '0;
    host_rd_en   = 1'b0;
    host_rd_addr = '0;
    host_wr_en   = 1'b0;
    host_wr_addr = '0;
    host_wr_data = '0;
    err_cnt      = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    $readmemh("sim/gf2_systemizer_tests.dat", tests);
    repeat (4) @(negedge clk);   // Reset over 4 cycles
    rst_n = 1'b1;
    @(negedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      base        = t * REC_LEN;
      errs_before = err_cnt;
      if ($isunknown(tests[base])) begin
        $display("Test file holds fewer records than expected, record %0d missing", t);
        err_cnt++;
        break;
      end
      for (int r = 0; r < ROW_CNT; r++)
        write_row(row_addr_t'(r), tests[base + 2 + r]);
      // Round trip through the host port
      for (int r = 0; r < ROW_CNT; r++) begin
        read_row(row_addr_t'(r), got);
        check_row(got, tests[base + 2 + r], $sformatf("readback row %0d", r));
      end
      run_engine(blk_idx_t'(tests[base + 1]));
      check_flag(fail, tests[base + 2 + ROW_CNT][0], "fail flag at done");
      for (int r = 0; r < ROW_CNT; r++) begin
        read_row(row_addr_t'(r), got);
        check_row(got, tests[base + 3 + ROW_CNT + r], $sformatf("result row %0d", r));
      end
      if (err_cnt == errs_before) begin
        pass_cnt++;
        $display("Test %0d, start block %0d: passed", tests[base], tests[base + 1]);
      end else begin
        fail_cnt++;
        $display("Test %0d, start block %0d: failed", tests[base], tests[base + 1]);
      end
    end
    err_cnt += gf2_systemizer_i.gauss_phase_i.checker_i.assert_fails;   // Bound assertions
    $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && pass_cnt == NUM_TESTS)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // Watchdog sized from the test count
  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Run timed out after %0d cycles, the DUT never finished", WATCHDOG_CYC);
    $display("Something failed");
    $finish;
  end

endmodule

//--- gf2_systemizer.f
logic/gauss_pkg.sv
logic/row_mem_if.sv
logic/row_mem.sv
logic/gauss_step.sv
logic/gauss_phase.sv
logic/gf2_systemizer.sv
sim/gf2_systemizer_checker.sv
sim/gf2_systemizer_tb.sv

//--- sim/gf2_systemizer_tests.dat
// One record per line, hex words:
// code start_block in_row0..in_row7 exp_fail exp_row0..exp_row7
// Full rank, block 0, swap needed on column 0
1 0 8110 690B 96C0 3306 C380 7118 B2A4 2B60 0 A501 3C02 0F04 F008 8110 7E20 5540 C380
// Singular, no pivot in column 5
2 0 1203 3402 5614 7808 9A50 BC91 DE40 F0C4 1 2601 3402 CC44 7808 9A50 00C0 DE40 3C80
// Block 0 already reduced, run from block 1
3 1 E121 2202 8794 BB48 FFC0 3C50 CC80 0FE0 0 1101 2202 4404 8808 0F10 F020 3340 CC80
// Start block past the end, rows untouched
4 2 0123 4567 89AB CDEF FEDC BA98 7654 3210 0 0123 4567 89AB CDEF FEDC BA98 7654 3210
// Column 0 empty, fails on the first search
5 0 1E02 2D04 3C06 4B08 5A0A 690C 780E 87F0 1 1E02 2D04 3C06 4B08 5A0A 690C 780E 87F0
